/* hw/shape_pkg.sv */
package shape_pkg;

	// image geometry
	localparam int IMG_COLS = 200;
	localparam int IMG_ROWS = 240;

	// column and row indices
	typedef logic [7:0] x_t;
	typedef logic [7:0] y_t;

	// blob width in columns, 1..IMG_COLS, zero when no blob
	typedef logic [7:0] span_t;

	localparam x_t X_LAST = x_t'(IMG_COLS - 1);	// rightmost column index

	// left run tracker
	typedef enum logic [1:0] {
		IDLE,	// no foreground column yet
		IN_RUN,
		DONE	// first run closed, frozen until next frame
	} run_state_t;

endpackage

/* hw/left_run_scan.sv */
module left_run_scan (
	input  logic          clk,
	input  logic          resetn,
	input  logic          frame_start,
	input  logic          col_en,
	input  shape_pkg::x_t col_x,
	input  logic          col_valid,
	input  shape_pkg::y_t col_top,
	input  shape_pkg::y_t col_bot,

	output logic          lft_found,
	output logic          lft_touch,
	output shape_pkg::x_t lft_edge,
	output shape_pkg::x_t lft_run_end,
	output shape_pkg::x_t lft_top_x,
	output shape_pkg::y_t lft_top_y,
	output shape_pkg::x_t lft_bot_x,
	output shape_pkg::y_t lft_bot_y
);
	shape_pkg::run_state_t state;

	// stream order bookkeeping, only read by the checks below
	shape_pkg::x_t last_x;
	logic          seen_col;

	always_ff @(posedge clk) begin
		if (!resetn || frame_start) begin
			state       <= shape_pkg::IDLE;
			lft_found   <= 1'b0;
			lft_touch   <= 1'b0;
			lft_edge    <= '0;
			lft_run_end <= '0;
			lft_top_x   <= '0;
			lft_top_y   <= '0;
			lft_bot_x   <= '0;
			lft_bot_y   <= '0;
		end else if (col_en) begin
			case (state)
				shape_pkg::IDLE: begin
					if (col_valid) begin
						state       <= shape_pkg::IN_RUN;
						lft_found   <= 1'b1;
						lft_touch   <= (col_x == '0);
						lft_edge    <= col_x;
						lft_run_end <= col_x;
						lft_top_x   <= col_x;	// seed both corners
						lft_top_y   <= col_top;
						lft_bot_x   <= col_x;
						lft_bot_y   <= col_bot;
					end
				end
				shape_pkg::IN_RUN: begin
					if (col_valid) begin
						lft_run_end <= col_x;
						// ties go to the later column
						if (col_top <= lft_top_y) begin
							lft_top_x <= col_x;
							lft_top_y <= col_top;
						end
						if (col_bot >= lft_bot_y) begin
							lft_bot_x <= col_x;
							lft_bot_y <= col_bot;
						end
					end else begin
						state <= shape_pkg::DONE;
					end
				end
				default: ;	// DONE holds until frame_start
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn || frame_start)
			seen_col <= 1'b0;
		else if (col_en)
			seen_col <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (col_en)
			last_x <= col_x;
	end

	a_col_rows: assert property (@(posedge clk) disable iff (!resetn)
		col_en && col_valid |-> col_top <= col_bot && col_bot < shape_pkg::IMG_ROWS);

	a_col_order: assert property (@(posedge clk) disable iff (!resetn)
		col_en && seen_col && !frame_start |-> col_x > last_x);

endmodule

/* hw/right_run_scan.sv */
module right_run_scan (
	input  logic          clk,
	input  logic          resetn,
	input  logic          frame_start,
	input  logic          col_en,
	input  shape_pkg::x_t col_x,
	input  logic          col_valid,
	input  shape_pkg::y_t col_top,
	input  shape_pkg::y_t col_bot,

	output logic          rt_found,
	output logic          rt_touch,
	output shape_pkg::x_t rt_edge,
	output shape_pkg::x_t rt_run_start,
	output shape_pkg::x_t rt_top_x,
	output shape_pkg::y_t rt_top_y,
	output shape_pkg::x_t rt_bot_x,
	output shape_pkg::y_t rt_bot_y
);
	logic in_run;	// previous column was foreground

	// run level follows every strobe
	always_ff @(posedge clk) begin
		if (!resetn || frame_start)
			in_run <= 1'b0;
		else if (col_en)
			in_run <= col_valid;
	end

	always_ff @(posedge clk) begin
		if (!resetn || frame_start) begin
			rt_found <= 1'b0;
			rt_touch <= 1'b0;
		end else if (col_en) begin
			if (col_valid)
				rt_found <= 1'b1;
			if (col_x == shape_pkg::X_LAST)
				rt_touch <= col_valid;
		end
	end

	// a new run after a gap discards whatever the older run left behind
	always_ff @(posedge clk) begin
		if (!resetn || frame_start) begin
			rt_edge      <= '0;
			rt_run_start <= '0;
			rt_top_x     <= '0;
			rt_top_y     <= '0;
			rt_bot_x     <= '0;
			rt_bot_y     <= '0;
		end else if (col_en && col_valid) begin
			rt_edge <= col_x;
			if (!in_run) begin
				rt_run_start <= col_x;
				rt_top_x     <= col_x;
				rt_top_y     <= col_top;
				rt_bot_x     <= col_x;
				rt_bot_y     <= col_bot;
			end else begin
				if (col_top < rt_top_y) begin	// strict, earlier x keeps ties
					rt_top_x <= col_x;
					rt_top_y <= col_top;
				end
				if (col_bot > rt_bot_y) begin
					rt_bot_x <= col_x;
					rt_bot_y <= col_bot;
				end
			end
		end
	end

	// clearing and sampling on one edge would lose the column
	a_start_vs_col: assert property (@(posedge clk) disable iff (!resetn)
		!(frame_start && col_en));

endmodule

/* hw/profile_combine.sv */
module profile_combine (
	input  logic            clk,
	input  logic            resetn,
	input  logic            frame_end,

	input  logic            scan_lft_found,
	input  logic            scan_lft_touch,
	input  shape_pkg::x_t   scan_lft_edge,
	input  shape_pkg::x_t   scan_lft_run_end,
	input  shape_pkg::x_t   scan_lft_top_x,
	input  shape_pkg::y_t   scan_lft_top_y,
	input  shape_pkg::x_t   scan_lft_bot_x,
	input  shape_pkg::y_t   scan_lft_bot_y,
	input  logic            scan_rt_found,
	input  logic            scan_rt_touch,
	input  shape_pkg::x_t   scan_rt_edge,
	input  shape_pkg::x_t   scan_rt_run_start,
	input  shape_pkg::x_t   scan_rt_top_x,
	input  shape_pkg::y_t   scan_rt_top_y,
	input  shape_pkg::x_t   scan_rt_bot_x,
	input  shape_pkg::y_t   scan_rt_bot_y,

	output logic            done,
	output logic            lft_found,
	output logic            lft_touch,
	output shape_pkg::x_t   lft_edge,
	output shape_pkg::x_t   lft_top_x,
	output shape_pkg::y_t   lft_top_y,
	output shape_pkg::x_t   lft_bot_x,
	output shape_pkg::y_t   lft_bot_y,
	output logic            rt_found,
	output logic            rt_touch,
	output shape_pkg::x_t   rt_edge,
	output shape_pkg::x_t   rt_top_x,
	output shape_pkg::y_t   rt_top_y,
	output shape_pkg::x_t   rt_bot_x,
	output shape_pkg::y_t   rt_bot_y,
	output shape_pkg::span_t span,
	output logic            single_seg
);
	logic            any_run;
	shape_pkg::span_t span_nxt;
	logic            one_run;

	assign any_run  = scan_lft_found && scan_rt_found;
	assign span_nxt = any_run ? shape_pkg::span_t'(scan_rt_edge - scan_lft_edge) + 8'd1 : '0;
	// first and last run are the same run
	assign one_run  = any_run && (scan_lft_run_end == scan_rt_edge)
		&& (scan_lft_edge == scan_rt_run_start);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			done       <= 1'b0;
			lft_found  <= 1'b0;
			lft_touch  <= 1'b0;
			lft_edge   <= '0;
			lft_top_x  <= '0;
			lft_top_y  <= '0;
			lft_bot_x  <= '0;
			lft_bot_y  <= '0;
			rt_found   <= 1'b0;
			rt_touch   <= 1'b0;
			rt_edge    <= '0;
			rt_top_x   <= '0;
			rt_top_y   <= '0;
			rt_bot_x   <= '0;
			rt_bot_y   <= '0;
			span       <= '0;
			single_seg <= 1'b0;
		end else begin
			done <= frame_end;
			if (frame_end) begin	// results held until the next frame ends
				lft_found  <= scan_lft_found;
				lft_touch  <= scan_lft_touch;
				lft_edge   <= scan_lft_edge;
				lft_top_x  <= scan_lft_top_x;
				lft_top_y  <= scan_lft_top_y;
				lft_bot_x  <= scan_lft_bot_x;
				lft_bot_y  <= scan_lft_bot_y;
				rt_found   <= scan_rt_found;
				rt_touch   <= scan_rt_touch;
				rt_edge    <= scan_rt_edge;
				rt_top_x   <= scan_rt_top_x;
				rt_top_y   <= scan_rt_top_y;
				rt_bot_x   <= scan_rt_bot_x;
				rt_bot_y   <= scan_rt_bot_y;
				span       <= span_nxt;
				single_seg <= one_run;
			end
		end
	end

	a_done_pulse: assert property (@(posedge clk) disable iff (!resetn)
		done |=> !done);

endmodule

/* hw/shape_analyzer.sv */
module shape_analyzer (
	input  logic             clk,
	input  logic             resetn,
	input  logic             frame_start,
	input  logic             col_en,
	input  shape_pkg::x_t    col_x,
	input  logic             col_valid,
	input  shape_pkg::y_t    col_top,
	input  shape_pkg::y_t    col_bot,
	input  logic             frame_end,

	output logic             done,
	output logic             lft_found,
	output logic             lft_touch,
	output shape_pkg::x_t    lft_edge,
	output shape_pkg::x_t    lft_top_x,
	output shape_pkg::y_t    lft_top_y,
	output shape_pkg::x_t    lft_bot_x,
	output shape_pkg::y_t    lft_bot_y,
	output logic             rt_found,
	output logic             rt_touch,
	output shape_pkg::x_t    rt_edge,
	output shape_pkg::x_t    rt_top_x,
	output shape_pkg::y_t    rt_top_y,
	output shape_pkg::x_t    rt_bot_x,
	output shape_pkg::y_t    rt_bot_y,
	output shape_pkg::span_t span,
	output logic             single_seg
);
	// live scanner state, sampled by the combiner at frame end
	logic          s_lft_found, s_lft_touch;
	shape_pkg::x_t s_lft_edge, s_lft_run_end, s_lft_top_x, s_lft_bot_x;
	shape_pkg::y_t s_lft_top_y, s_lft_bot_y;
	logic          s_rt_found, s_rt_touch;
	shape_pkg::x_t s_rt_edge, s_rt_run_start, s_rt_top_x, s_rt_bot_x;
	shape_pkg::y_t s_rt_top_y, s_rt_bot_y;

	left_run_scan u_left (
		.clk(clk), .resetn(resetn), .frame_start(frame_start),
		.col_en(col_en), .col_x(col_x), .col_valid(col_valid),
		.col_top(col_top), .col_bot(col_bot),
		.lft_found(s_lft_found), .lft_touch(s_lft_touch),
		.lft_edge(s_lft_edge), .lft_run_end(s_lft_run_end),
		.lft_top_x(s_lft_top_x), .lft_top_y(s_lft_top_y),
		.lft_bot_x(s_lft_bot_x), .lft_bot_y(s_lft_bot_y)
	);

	right_run_scan u_right (
		.clk(clk), .resetn(resetn), .frame_start(frame_start),
		.col_en(col_en), .col_x(col_x), .col_valid(col_valid),
		.col_top(col_top), .col_bot(col_bot),
		.rt_found(s_rt_found), .rt_touch(s_rt_touch),
		.rt_edge(s_rt_edge), .rt_run_start(s_rt_run_start),
		.rt_top_x(s_rt_top_x), .rt_top_y(s_rt_top_y),
		.rt_bot_x(s_rt_bot_x), .rt_bot_y(s_rt_bot_y)
	);

	profile_combine u_comb (
		.clk(clk), .resetn(resetn), .frame_end(frame_end),
		.scan_lft_found(s_lft_found), .scan_lft_touch(s_lft_touch),
		.scan_lft_edge(s_lft_edge), .scan_lft_run_end(s_lft_run_end),
		.scan_lft_top_x(s_lft_top_x), .scan_lft_top_y(s_lft_top_y),
		.scan_lft_bot_x(s_lft_bot_x), .scan_lft_bot_y(s_lft_bot_y),
		.scan_rt_found(s_rt_found), .scan_rt_touch(s_rt_touch),
		.scan_rt_edge(s_rt_edge), .scan_rt_run_start(s_rt_run_start),
		.scan_rt_top_x(s_rt_top_x), .scan_rt_top_y(s_rt_top_y),
		.scan_rt_bot_x(s_rt_bot_x), .scan_rt_bot_y(s_rt_bot_y),
		.done(done), .lft_found(lft_found), .lft_touch(lft_touch),
		.lft_edge(lft_edge), .lft_top_x(lft_top_x), .lft_top_y(lft_top_y),
		.lft_bot_x(lft_bot_x), .lft_bot_y(lft_bot_y),
		.rt_found(rt_found), .rt_touch(rt_touch), .rt_edge(rt_edge),
		.rt_top_x(rt_top_x), .rt_top_y(rt_top_y),
		.rt_bot_x(rt_bot_x), .rt_bot_y(rt_bot_y),
		.span(span), .single_seg(single_seg)
	);

endmodule

/* test/tb_shape_analyzer.sv */
module tb_shape_analyzer;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int COLS = shape_pkg::IMG_COLS;
	localparam int DONE_TIMEOUT = 20;	// cycles from frame_end to done

	typedef struct packed {
		logic             lft_found, lft_touch;
		shape_pkg::x_t    lft_edge, lft_top_x, lft_bot_x;
		shape_pkg::y_t    lft_top_y, lft_bot_y;
		logic             rt_found, rt_touch;
		shape_pkg::x_t    rt_edge, rt_top_x, rt_bot_x;
		shape_pkg::y_t    rt_top_y, rt_bot_y;
		shape_pkg::span_t span;
		logic             single_seg;
	} result_t;

	logic             clk, resetn, frame_start, col_en, col_valid, frame_end;
	shape_pkg::x_t    col_x;
	shape_pkg::y_t    col_top, col_bot;
	logic             done, lft_found, lft_touch, rt_found, rt_touch, single_seg;
	shape_pkg::x_t    lft_edge, lft_top_x, lft_bot_x, rt_edge, rt_top_x, rt_bot_x;
	shape_pkg::y_t    lft_top_y, lft_bot_y, rt_top_y, rt_bot_y;
	shape_pkg::span_t span;

	shape_analyzer u_dut (.*);

	result_t act, expected;
	result_t held = '0;	// outputs as loaded by the last done
	assign act = {lft_found, lft_touch, lft_edge, lft_top_x, lft_bot_x, lft_top_y, lft_bot_y,
		rt_found, rt_touch, rt_edge, rt_top_x, rt_bot_x, rt_top_y, rt_bot_y, span, single_seg};

	// column profile of the frame in flight
	bit            pv [COLS];
	shape_pkg::y_t pt [COLS];
	shape_pkg::y_t pb [COLS];

	logic [31:0] lfsr_state = 32'h0a8d_2767;
	string       cur_test = "reset";
	int          tests_run, pass_count, fail_count, err_count, test_errs;
	logic        done_prev = 1'b0;
	bit          timed_out = 1'b0;

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};	// taps 32 22 2 1
	endfunction

	function automatic int unsigned rand_bits(input int n);
		int unsigned v;
		v = 0;
		repeat (n) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = (v << 1) | lfsr_state[0];
		end
		return v;
	endfunction

	task automatic fill_col(input int x, input bit v);
		pv[x] = v;
		pt[x] = shape_pkg::y_t'(1 + rand_bits(7));
		pb[x] = pt[x] + shape_pkg::y_t'(rand_bits(6));	// stays below IMG_ROWS
	endtask

	task automatic add_run(input int lo, input int hi);
		for (int x = lo; x <= hi; x++)
			fill_col(x, 1'b1);
	endtask

	task automatic clear_profile();
		for (int x = 0; x < COLS; x++)
			fill_col(x, 1'b0);
	endtask

	task automatic random_profile();
		bit v;
		v = bit'(rand_bits(1));
		for (int x = 0; x < COLS; x++) begin
			if (rand_bits(3) == 0)
				v = !v;	// about one toggle in eight columns
			fill_col(x, v);
		end
	endtask

	function automatic result_t ref_model();
		result_t r;
		int first, first_end, last, last_start, x;
		r = '0;
		first = -1;
		for (x = COLS - 1; x >= 0; x--)
			if (pv[x])
				first = x;
		if (first < 0)
			return r;
		last = COLS - 1;
		while (!pv[last])
			last--;
		first_end = first;
		while (first_end < COLS - 1 && pv[first_end + 1])
			first_end++;
		last_start = last;
		while (last_start > 0 && pv[last_start - 1])
			last_start--;
		r.lft_found = 1'b1;
		r.lft_touch = pv[0];
		r.lft_edge = shape_pkg::x_t'(first);
		r.lft_top_y = 8'hff;
		for (x = first; x <= first_end; x++) begin	// later x wins ties
			if (pt[x] <= r.lft_top_y) {r.lft_top_x, r.lft_top_y} = {shape_pkg::x_t'(x), pt[x]};
			if (pb[x] >= r.lft_bot_y) {r.lft_bot_x, r.lft_bot_y} = {shape_pkg::x_t'(x), pb[x]};
		end
		r.rt_found = 1'b1;
		r.rt_touch = pv[COLS - 1];
		r.rt_edge = shape_pkg::x_t'(last);
		r.rt_top_y = 8'hff;
		for (x = last; x >= last_start; x--) begin	// walking back, so earlier x wins ties
			if (pt[x] <= r.rt_top_y) {r.rt_top_x, r.rt_top_y} = {shape_pkg::x_t'(x), pt[x]};
			if (pb[x] >= r.rt_bot_y) {r.rt_bot_x, r.rt_bot_y} = {shape_pkg::x_t'(x), pb[x]};
		end
		r.span = shape_pkg::span_t'(last - first + 1);
		r.single_seg = (first_end == last);
		return r;
	endfunction

	task automatic check_bit(input string what, input logic exp_v, input logic act_v);
		if (exp_v !== act_v) begin
			$display("Fail %s %s: expected %0d, actual %0d", cur_test, what, exp_v, act_v);
			test_errs++;
		end
	endtask

	task automatic check_x(input string what, input shape_pkg::x_t exp_v,
		input shape_pkg::x_t act_v);
		if (exp_v !== act_v) begin
			$display("Fail %s %s: expected %0d, actual %0d", cur_test, what, exp_v, act_v);
			test_errs++;
		end
	endtask

	task automatic check_y(input string what, input shape_pkg::y_t exp_v,
		input shape_pkg::y_t act_v);
		if (exp_v !== act_v) begin
			$display("Fail %s %s: expected %0d, actual %0d", cur_test, what, exp_v, act_v);
			test_errs++;
		end
	endtask

	task automatic check_span(input string what, input shape_pkg::span_t exp_v,
		input shape_pkg::span_t act_v);
		if (exp_v !== act_v) begin
			$display("Fail %s %s: expected %0d, actual %0d", cur_test, what, exp_v, act_v);
			test_errs++;
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		if (resetn) begin
			if (done) begin
				if (done_prev) begin
					$display("%s: done stayed high for more than one cycle", cur_test);
					err_count++;
				end
				test_errs = 0;
				check_bit("lft_found", expected.lft_found, act.lft_found);
				check_bit("lft_touch", expected.lft_touch, act.lft_touch);
				check_x("lft_edge", expected.lft_edge, act.lft_edge);
				check_x("lft_top_x", expected.lft_top_x, act.lft_top_x);
				check_y("lft_top_y", expected.lft_top_y, act.lft_top_y);
				check_x("lft_bot_x", expected.lft_bot_x, act.lft_bot_x);
				check_y("lft_bot_y", expected.lft_bot_y, act.lft_bot_y);
				check_bit("rt_found", expected.rt_found, act.rt_found);
				check_bit("rt_touch", expected.rt_touch, act.rt_touch);
				check_x("rt_edge", expected.rt_edge, act.rt_edge);
				check_x("rt_top_x", expected.rt_top_x, act.rt_top_x);
				check_y("rt_top_y", expected.rt_top_y, act.rt_top_y);
				check_x("rt_bot_x", expected.rt_bot_x, act.rt_bot_x);
				check_y("rt_bot_y", expected.rt_bot_y, act.rt_bot_y);
				check_span("span", expected.span, act.span);
				check_bit("single_seg", expected.single_seg, act.single_seg);
				if (test_errs == 0) begin
					$display("%s: ok", cur_test);
					pass_count++;
				end else begin
					$display("%s: %0d wrong outputs", cur_test, test_errs);
					fail_count++;
				end
				held = act;
			end else if (act !== held) begin
				$display("%s: results changed while no frame was ending", cur_test);
				err_count++;
			end
			done_prev = done;
		end
	end

	task automatic run_frame(input string name, input bit gaps);
		int wait_cycles;
		if (timed_out)
			return;	// DUT stopped answering
		cur_test = name;
		expected = ref_model();
		tests_run++;
		frame_start = 1'b1;
		@(negedge clk);
		frame_start = 1'b0;
		for (int x = 0; x < COLS; x++) begin
			if (gaps)
				repeat (rand_bits(2)) @(negedge clk);
			col_en = 1'b1;
			col_x = shape_pkg::x_t'(x);
			col_valid = pv[x];
			col_top = pt[x];
			col_bot = pb[x];
			@(negedge clk);
			col_en = 1'b0;
		end
		frame_end = 1'b1;
		@(negedge clk);
		frame_end = 1'b0;
		wait_cycles = 0;
		while (!done && wait_cycles < DONE_TIMEOUT) begin
			@(negedge clk);
			wait_cycles++;
		end
		if (!done) begin
			$display("%s: done did not arrive within %0d cycles of frame_end", name, DONE_TIMEOUT);
			err_count++;
			timed_out = 1'b1;
		end else begin
			if (wait_cycles != 0) begin
				$display("%s: done came %0d cycles late", name, wait_cycles);
				err_count++;
			end
			@(negedge clk);
		end
	endtask

	initial begin
		resetn = 1'b0;
		frame_start = 1'b0;
		col_en = 1'b0;
		col_x = '0;
		col_valid = 1'b0;
		col_top = '0;
		col_bot = '0;
		frame_end = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		resetn = 1'b1;
		@(negedge clk);
		clear_profile();
		run_frame("empty_frame", 1'b0);
		add_run(50, 90);
		run_frame("interior_blob", 1'b0);
		add_run(0, COLS - 1);
		run_frame("full_width", 1'b0);
		clear_profile();
		add_run(10, 30);
		add_run(70, 100);
		add_run(150, 180);
		run_frame("three_blobs", 1'b0);
		clear_profile();
		add_run(40, 60);
		pt[44] = '0;	// three equal tops and two equal bottoms
		pt[50] = '0;
		pt[56] = '0;
		pb[43] = 8'd239;
		pb[57] = 8'd239;
		run_frame("corner_ties", 1'b0);
		for (int i = 0; i < 30; i++) begin
			random_profile();
			run_frame($sformatf("random_%0d", i), 1'b1);
		end
		$display("tests %0d, passed %0d, failed %0d, other errors %0d",
			tests_run, pass_count, fail_count, err_count);
		if (fail_count == 0 && err_count == 0 && pass_count == tests_run)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* build.f */
hw/shape_pkg.sv
hw/left_run_scan.sv
hw/right_run_scan.sv
hw/profile_combine.sv
hw/shape_analyzer.sv
test/tb_shape_analyzer.sv
